/* all.f */
+incdir+design
design/pipe_ctrl_pkg.sv
design/pipeline_control.sv
design/load_use_detect.sv
design/mul_div_sequencer.sv
design/stage_regs.sv
design/pipe_ctrl_top.sv
testbench/pipe_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := pipe_ctrl_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`include "pipe_ctrl_defines.svh"

module pipe_ctrl_tb;

  localparam int PROG_LEN  = 15;
  localparam int TRACE_LEN = 40;
  localparam int WAIT_MAX  = 3000;

  logic                clk;
  logic                rst;
  logic [`PC_W-1:0]    imem_addr_o;
  logic [`INSTR_W-1:0] imem_rdata_i;
  logic                imem_rvalid_i;
  logic                dmem_busy_i;
  logic                ifram_busy_i;
  logic                trap_flush_i;
  logic                trap_csr_i;
  logic [`CTRL_W-1:0]  stall_o;
  logic [`CTRL_W-1:0]  flush_o;
  logic                retire_valid_o;
  logic [`PC_W-1:0]    retire_pc_o;
  logic [`INSTR_W-1:0] retire_instr_o;

  logic [31:0]      prog     [0:PROG_LEN-1];
  logic [`PC_W-1:0] trace_pc [0:TRACE_LEN-1];
  logic [31:0]      trace_word [0:TRACE_LEN-1];

  integer seed = 32'hddff60f2;
  logic   random_gaps;
  int     ret_idx;
  int     value_errors;
  int     other_errors;
  int     mul_run;
  logic   interfered;
  int     reset_hits;
  int     lu_hits;
  int     mul_hits;
  int     dmem_hits;
  int     ifram_hits;
  int     tflush_hits;
  int     tcsr_hits;

  // peeks at the decode and execute slots
  logic [31:0] ex_word;
  logic [31:0] id_word;
  logic        ex_valid;
  logic        ex_is_mul;
  logic        lu_hit;
  logic        no_outside;

  pipe_ctrl_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .imem_addr_o    (imem_addr_o),
    .imem_rdata_i   (imem_rdata_i),
    .imem_rvalid_i  (imem_rvalid_i),
    .dmem_busy_i    (dmem_busy_i),
    .ifram_busy_i   (ifram_busy_i),
    .trap_flush_i   (trap_flush_i),
    .trap_csr_i     (trap_csr_i),
    .stall_o        (stall_o),
    .flush_o        (flush_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  // addi x0 nop whose immediate folds in every address bit
  function automatic logic [31:0] fetch_word(input logic [`PC_W-1:0] addr);
    logic [11:0] imm;
    imm = addr[31:20] ^ addr[19:8] ^ addr[11:0];
    if (addr < 32'(PROG_LEN * 4)) begin
      return prog[addr[5:2]];
    end
    return {imm, 5'd0, 3'd0, 5'd0, 7'b0010011};
  endfunction

  // next pc in program order or the jal target
  function automatic logic [`PC_W-1:0] next_pc(input logic [`PC_W-1:0] pc,
                                               input logic [31:0] w);
    if (w[6:0] == `OP_JAL) begin
      return pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    end
    return pc + 32'd4;
  endfunction

  task automatic check_ctrl(input string name, input logic [`CTRL_W-1:0] exp,
                            input logic [`CTRL_W-1:0] got);
    assert (got === exp) else begin
      $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, got);
      value_errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
      value_errors++;
    end
  endtask

  task automatic require_hits(input string name, input int hits);
    if (hits == 0) begin
      $display("the %s check was never reached", name);
      other_errors++;
    end
  endtask

  task automatic hold_requests(input logic d, input logic i, input logic f, input logic c,
                               input int cycles);
    @(posedge clk);
    dmem_busy_i  <= d;
    ifram_busy_i <= i;
    trap_flush_i <= f;
    trap_csr_i   <= c;
    repeat (cycles) @(posedge clk);
    dmem_busy_i  <= 1'b0;
    ifram_busy_i <= 1'b0;
    trap_flush_i <= 1'b0;
    trap_csr_i   <= 1'b0;
    repeat (3) @(posedge clk); // let the pipe settle
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign imem_rdata_i = fetch_word(imem_addr_o); // same cycle answer
  assign ex_word      = dut_i.ex_instr;
  assign id_word      = dut_i.id_instr;
  assign ex_valid     = dut_i.ex_valid;
  assign ex_is_mul    = ex_valid && (ex_word[6:0] == `OP_OP) && ex_word[25];
  assign lu_hit       = ex_valid && (ex_word[6:0] == `OP_LOAD) && (ex_word[11:7] != 5'd0) &&
                        ((ex_word[11:7] == id_word[19:15]) || (ex_word[11:7] == id_word[24:20]));
  assign no_outside   = !dmem_busy_i && !ifram_busy_i && !trap_flush_i && !trap_csr_i;

  always @(posedge clk) begin
    imem_rvalid_i <= random_gaps ? (($random(seed) & 7) != 0) : 1'b1; // about 1 in 8 dropped
  end

  always @(negedge clk) begin
    if (rst) begin
      reset_hits++;
      check_ctrl("stall_o", 6'b000000, stall_o);
      check_ctrl("flush_o", 6'b011111, flush_o);
    end else begin
      if (retire_valid_o && ret_idx < TRACE_LEN) begin
        check_word("retire_pc_o", trace_pc[ret_idx], retire_pc_o);
        check_word("retire_instr_o", trace_word[ret_idx], retire_instr_o);
        ret_idx++;
      end
      if (lu_hit && no_outside && imem_rvalid_i) begin
        lu_hits++;
        check_ctrl("stall_o", 6'b000011, stall_o);
        check_ctrl("flush_o", 6'b000100, flush_o);
      end
      // a run that a memory stall cut into is not judged
      if (!ex_is_mul) interfered = 1'b0;
      if (ex_is_mul && stall_o == 6'b001111) interfered = 1'b1;
      if (stall_o == 6'b000111) begin
        mul_run++;
      end else if (mul_run != 0) begin
        if (!interfered) begin
          mul_hits++;
          assert (mul_run == `MUL_DIV_CYCLES) else begin
            $display("ERROR t=%0t stall_o mul/div run expected %0d actual %0d",
                     $time, `MUL_DIV_CYCLES, mul_run);
            value_errors++;
          end
        end
        mul_run = 0;
      end
      if (dmem_busy_i) begin
        dmem_hits++;
        check_ctrl("stall_o", 6'b001111, stall_o);
        check_ctrl("flush_o", 6'b010000, flush_o);
      end
      if (ifram_busy_i && !dmem_busy_i && imem_rvalid_i) begin
        ifram_hits++;
        check_ctrl("stall_o", 6'b001111, stall_o);
        check_ctrl("flush_o", 6'b000000, flush_o);
      end
      if (trap_flush_i && !dmem_busy_i && !ifram_busy_i && imem_rvalid_i) begin
        tflush_hits++;
        check_ctrl("stall_o", 6'b000010, stall_o);
        check_ctrl("flush_o", 6'b001110, flush_o);
      end
      if (trap_csr_i && !trap_flush_i && !dmem_busy_i && !ifram_busy_i && imem_rvalid_i) begin
        tcsr_hits++;
        check_ctrl("stall_o", 6'b111111, stall_o);
        check_ctrl("flush_o", 6'b001110, flush_o);
        check_word("retire_valid_o", 32'd0, {31'd0, retire_valid_o});
      end
    end
  end

  initial begin
    logic [`PC_W-1:0] pc;
    int               cycles;
    rst           = 1'b1;
    imem_rvalid_i = 1'b0;
    dmem_busy_i   = 1'b0;
    ifram_busy_i  = 1'b0;
    trap_flush_i  = 1'b0;
    trap_csr_i    = 1'b0;
    random_gaps   = 1'b1;
    ret_idx       = 0;
    value_errors  = 0;
    other_errors  = 0;
    mul_run       = 0;
    interfered    = 1'b0;
    prog[0]  = enc_i(7'b0010011, 12'd16, 5'd0, 3'd0, 5'd1); // addi x1
    prog[1]  = enc_i(`OP_LOAD, 12'd0, 5'd1, 3'b010, 5'd2);
    prog[2]  = enc_r(7'd0, 5'd1, 5'd2, 3'd0, 5'd3);         // uses x2 right away
    prog[3]  = enc_r(7'd1, 5'd2, 5'd3, 3'd0, 5'd4);         // mul
    prog[4]  = enc_r(7'd1, 5'd3, 5'd4, 3'd4, 5'd5);         // div back to back
    prog[5]  = enc_jal(5'd0, 21'd12);
    prog[6]  = enc_r(7'd0, 5'd1, 5'd1, 3'd0, 5'd11);        // jumped over
    prog[7]  = enc_r(7'd0, 5'd1, 5'd1, 3'd0, 5'd12);
    prog[8]  = enc_i(`OP_LOAD, 12'd4, 5'd1, 3'b010, 5'd6);
    prog[9]  = enc_s(12'd8, 5'd6, 5'd1);                    // store data from load
    prog[10] = enc_r(7'd1, 5'd6, 5'd6, 3'd0, 5'd7);
    prog[11] = enc_i(`OP_LOAD, 12'd0, 5'd0, 3'b010, 5'd8);
    prog[12] = enc_i(`OP_LOAD, 12'd0, 5'd8, 3'b010, 5'd9);  // address from load
    prog[13] = enc_r(7'd0, 5'd8, 5'd9, 3'd0, 5'd10);
    prog[14] = enc_jal(5'd0, 21'd0);                        // spin here
    pc = '0;
    for (int i = 0; i < TRACE_LEN; i++) begin
      trace_pc[i]   = pc;
      trace_word[i] = fetch_word(pc);
      pc = next_pc(pc, trace_word[i]);
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_word("retire_valid_o", 32'd0, {31'd0, retire_valid_o}); // nothing in flight yet

    cycles = 0;
    while (ret_idx < TRACE_LEN && cycles < WAIT_MAX) begin
      @(posedge clk);
      cycles++;
    end

    if (ret_idx < TRACE_LEN) begin
      $display("timeout: only %0d of %0d instructions retired", ret_idx, TRACE_LEN);
      other_errors++;
    end else begin
      random_gaps <= 1'b0;
      repeat (2) @(posedge clk);
      hold_requests(1'b1, 1'b0, 1'b0, 1'b0, 3);
      hold_requests(1'b0, 1'b1, 1'b0, 1'b0, 3);
      hold_requests(1'b0, 1'b0, 1'b1, 1'b0, 2);
      hold_requests(1'b0, 1'b0, 1'b0, 1'b1, 4);
      hold_requests(1'b1, 1'b0, 1'b1, 1'b0, 1); // data ram beats trap flush
      hold_requests(1'b0, 1'b1, 1'b0, 1'b1, 2);
      hold_requests(1'b0, 1'b0, 1'b1, 1'b1, 2);
      require_hits("reset", reset_hits);
      require_hits("load-use", lu_hits);
      require_hits("mul/div run", mul_hits);
      require_hits("data ram busy", dmem_hits);
      require_hits("instruction ram busy", ifram_hits);
      require_hits("trap flush", tflush_hits);
      require_hits("csr trap", tcsr_hits);
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* design/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`include "pipe_ctrl_defines.svh"

module pipe_ctrl_top (
  input  logic                clk,
  input  logic                rst,
  output logic [`PC_W-1:0]    imem_addr_o,
  input  logic [`INSTR_W-1:0] imem_rdata_i,
  input  logic                imem_rvalid_i,
  input  logic                dmem_busy_i,
  input  logic                ifram_busy_i,
  input  logic                trap_flush_i,
  input  logic                trap_csr_i,
  output logic [`CTRL_W-1:0]  stall_o,
  output logic [`CTRL_W-1:0]  flush_o,
  output logic                retire_valid_o,
  output logic [`PC_W-1:0]    retire_pc_o,
  output logic [`INSTR_W-1:0] retire_instr_o
);

  pipe_ctrl_pkg::instr_fields_t id_instr;
  pipe_ctrl_pkg::instr_fields_t ex_instr;
  logic                         ex_valid;
  logic                         mem_is_ls;
  logic                         jump_valid;
  logic                         load_use_valid;
  logic                         mul_div_valid;

  stage_regs u_stage_regs (
    .clk            (clk),
    .rst            (rst),
    .stall_i        (stall_o),
    .flush_i        (flush_o),
    .imem_rdata_i   (imem_rdata_i),
    .imem_rvalid_i  (imem_rvalid_i),
    .imem_addr_o    (imem_addr_o),
    .id_instr_o     (id_instr),
    .ex_instr_o     (ex_instr),
    .ex_valid_o     (ex_valid),
    .jump_valid_o   (jump_valid),
    .mem_is_ls_o    (mem_is_ls),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o)
  );

  load_use_detect u_load_use_detect (
    .id_instr_i       (id_instr),
    .ex_instr_i       (ex_instr),
    .ex_valid_i       (ex_valid),
    .load_use_valid_o (load_use_valid)
  );

  mul_div_sequencer u_mul_div_sequencer (
    .clk             (clk),
    .rst             (rst),
    .ex_instr_i      (ex_instr),
    .ex_valid_i      (ex_valid),
    .mul_div_valid_o (mul_div_valid)
  );

  // fetch valid doubles as the if ram data strobe
  pipeline_control u_pipeline_control (
    .rst              (rst),
    .ls_valid_i       (mem_is_ls),
    .if_rdata_valid_i (imem_rvalid_i),
    .ram_stall_mem_i  (dmem_busy_i),
    .ram_stall_if_i   (ifram_busy_i),
    .trap_flush_i     (trap_flush_i),
    .trap_stall_i     (trap_csr_i),
    .jump_valid_i     (jump_valid),
    .mul_div_valid_i  (mul_div_valid),
    .load_use_valid_i (load_use_valid),
    .stall_o          (stall_o),
    .flush_o          (flush_o)
  );

endmodule

/* design/stage_regs.sv */
`timescale 1ns/1ps
`include "pipe_ctrl_defines.svh"

module stage_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`CTRL_W-1:0]           stall_i,
  input  logic [`CTRL_W-1:0]           flush_i,
  input  logic [`INSTR_W-1:0]          imem_rdata_i,
  input  logic                         imem_rvalid_i,
  output logic [`PC_W-1:0]             imem_addr_o,
  output pipe_ctrl_pkg::instr_fields_t id_instr_o,
  output pipe_ctrl_pkg::instr_fields_t ex_instr_o,
  output logic                         ex_valid_o,
  output logic                         jump_valid_o,
  output logic                         mem_is_ls_o,
  output logic                         retire_valid_o,
  output logic [`PC_W-1:0]             retire_pc_o,
  output logic [`INSTR_W-1:0]          retire_instr_o
);

  localparam int FIRST = pipe_ctrl_pkg::IF_ID;
  localparam int LAST  = pipe_ctrl_pkg::MEM_WB;

  logic [`PC_W-1:0] pc_q;
  logic [`PC_W-1:0] pc_next;

  // one slot per pipeline register, indexed by stage position
  logic [`PC_W-1:0]             st_pc    [FIRST:LAST];
  pipe_ctrl_pkg::instr_fields_t st_instr [FIRST:LAST];
  logic [LAST:FIRST]            st_valid;

  // what each register would load this edge
  logic [`PC_W-1:0]             in_pc    [FIRST:LAST];
  pipe_ctrl_pkg::instr_fields_t in_instr [FIRST:LAST];
  logic [LAST:FIRST]            in_valid;

  pipe_ctrl_pkg::instr_fields_t ex_f;
  pipe_ctrl_pkg::instr_fields_t mem_f;
  logic [20:0]                  j_imm;
  logic [`PC_W-1:0]             jump_target;

  always_comb begin
    in_pc[FIRST]    = pc_q;
    in_instr[FIRST] = pipe_ctrl_pkg::instr_fields_t'(imem_rdata_i);
    in_valid[FIRST] = imem_rvalid_i;
    for (int k = FIRST + 1; k <= LAST; k++) begin
      in_pc[k]    = st_pc[k-1];
      in_instr[k] = st_instr[k-1];
      in_valid[k] = st_valid[k-1];
    end
  end

  assign ex_f  = st_instr[pipe_ctrl_pkg::ID_EX];
  assign mem_f = st_instr[pipe_ctrl_pkg::EX_MEM];

  // j-type immediate reassembled from the r-type field split
  assign j_imm = {ex_f.funct7[6], ex_f.rs1, ex_f.funct3, ex_f.rs2[0],
                  ex_f.funct7[5:0], ex_f.rs2[4:1], 1'b0};
  assign jump_target = st_pc[pipe_ctrl_pkg::ID_EX] +
                       {{(`PC_W-21){j_imm[20]}}, j_imm};

  assign jump_valid_o = st_valid[pipe_ctrl_pkg::ID_EX] && (ex_f.opcode == `OP_JAL);

  // a dropped fetch keeps the pc so nothing is skipped
  always_comb begin
    if (jump_valid_o) begin
      pc_next = jump_target;
    end else if (imem_rvalid_i) begin
      pc_next = pc_q + `PC_W'(4);
    end else begin
      pc_next = pc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else if (!stall_i[pipe_ctrl_pkg::PC]) begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = FIRST; k <= LAST; k++) begin
      if (!stall_i[k]) begin
        st_pc[k]    <= in_pc[k];
        st_instr[k] <= in_instr[k];
      end
    end
  end

  // flush squashes valid even on a held stage (jump, trap)
  always_ff @(posedge clk) begin
    if (rst) begin
      st_valid <= '0;
    end else begin
      for (int k = FIRST; k <= LAST; k++) begin
        if (flush_i[k]) begin
          st_valid[k] <= 1'b0;
        end else if (!stall_i[k]) begin
          st_valid[k] <= in_valid[k];
        end
      end
    end
  end

  assign imem_addr_o = pc_q;
  assign id_instr_o  = st_instr[pipe_ctrl_pkg::IF_ID];
  assign ex_instr_o  = ex_f;
  assign ex_valid_o  = st_valid[pipe_ctrl_pkg::ID_EX];
  assign mem_is_ls_o = st_valid[pipe_ctrl_pkg::EX_MEM] &&
                       ((mem_f.opcode == `OP_LOAD) || (mem_f.opcode == `OP_STORE));

  // writeback side stall blocks retirement
  assign retire_valid_o = st_valid[LAST] && !stall_i[pipe_ctrl_pkg::WB];
  assign retire_pc_o    = st_pc[LAST];
  assign retire_instr_o = st_instr[LAST];

endmodule

/* design/mul_div_sequencer.sv */
`timescale 1ns/1ps
`include "pipe_ctrl_defines.svh"

// holds execute for the fixed mul/div latency, then releases for one cycle
module mul_div_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  pipe_ctrl_pkg::instr_fields_t ex_instr_i,
  input  logic                         ex_valid_i,
  output logic                         mul_div_valid_o
);

  localparam int CNT_W = $clog2(`MUL_DIV_CYCLES + 1);
  localparam logic [CNT_W-1:0] last_cnt = CNT_W'(`MUL_DIV_CYCLES - 1);

  logic             is_mul_div;
  logic [CNT_W-1:0] cnt;
  logic             done; // release cycle, instruction leaves execute

  assign is_mul_div = ex_valid_i &&
                      (ex_instr_i.opcode == `OP_OP) &&
                      ex_instr_i.funct7[0];

  // high from the first cycle in execute, no extra registered delay
  assign mul_div_valid_o = is_mul_div && !done;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (done) begin
      done <= 1'b0;
    end else if (is_mul_div) begin
      if (cnt == last_cnt) begin
        cnt  <= '0;
        done <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else begin
      cnt <= '0; // squashed mid-count by a trap
    end
  end

endmodule

/* design/load_use_detect.sv */
`timescale 1ns/1ps
`include "pipe_ctrl_defines.svh"

// load in execute whose result the decode instruction reads next cycle
module load_use_detect (
  input  pipe_ctrl_pkg::instr_fields_t id_instr_i,
  input  pipe_ctrl_pkg::instr_fields_t ex_instr_i,
  input  logic                         ex_valid_i,
  output logic                         load_use_valid_o
);

  logic ex_is_load;
  logic rd_nonzero;
  logic rs1_hit;
  logic rs2_hit;

  assign ex_is_load = ex_valid_i && (ex_instr_i.opcode == `OP_LOAD);
  assign rd_nonzero = (ex_instr_i.rd != 5'd0); // x0 never creates a dependency

  // rs2 compared on every format, a false match only costs one bubble
  assign rs1_hit = (ex_instr_i.rd == id_instr_i.rs1);
  assign rs2_hit = (ex_instr_i.rd == id_instr_i.rs2);

  assign load_use_valid_o = ex_is_load && rd_nonzero && (rs1_hit || rs2_hit);

endmodule

/* design/pipeline_control.sv */
`timescale 1ns/1ps
`include "pipe_ctrl_defines.svh"

// later pipeline stages win over earlier ones
module pipeline_control (
  input  logic               rst,
  input  logic               ls_valid_i,       // load/store sitting in mem
  input  logic               if_rdata_valid_i, // fetch data valid this cycle
  input  logic               ram_stall_mem_i,  // data ram busy
  input  logic               ram_stall_if_i,   // instruction ram busy
  input  logic               trap_flush_i,
  input  logic               trap_stall_i,     // csr trap, freeze everything
  input  logic               jump_valid_i,     // from execute
  input  logic               mul_div_valid_i,  // from execute
  input  logic               load_use_valid_i, // from decode
  output logic [`CTRL_W-1:0] stall_o,
  output logic [`CTRL_W-1:0] flush_o
);

  localparam logic [`CTRL_W-1:0] one = 1;

  // single stage masks
  localparam logic [`CTRL_W-1:0] b_pc     = one << pipe_ctrl_pkg::PC;
  localparam logic [`CTRL_W-1:0] b_if_id  = one << pipe_ctrl_pkg::IF_ID;
  localparam logic [`CTRL_W-1:0] b_id_ex  = one << pipe_ctrl_pkg::ID_EX;
  localparam logic [`CTRL_W-1:0] b_ex_mem = one << pipe_ctrl_pkg::EX_MEM;
  localparam logic [`CTRL_W-1:0] b_mem_wb = one << pipe_ctrl_pkg::MEM_WB;
  localparam logic [`CTRL_W-1:0] b_wb     = one << pipe_ctrl_pkg::WB;

  localparam logic [`CTRL_W-1:0] front_four = b_pc | b_if_id | b_id_ex | b_ex_mem;
  localparam logic [`CTRL_W-1:0] mid_three  = b_if_id | b_id_ex | b_ex_mem;

  // memory side, hold up to ex/mem and bubble into mem/wb
  localparam logic [`CTRL_W-1:0] ram_mem_stall = front_four;
  localparam logic [`CTRL_W-1:0] ram_mem_flush = b_mem_wb;
  localparam logic [`CTRL_W-1:0] ram_if_stall  = front_four;
  localparam logic [`CTRL_W-1:0] ram_if_flush  = '0;

  localparam logic [`CTRL_W-1:0] trap_flush_stall = b_if_id;
  localparam logic [`CTRL_W-1:0] trap_flush_flush = mid_three;
  localparam logic [`CTRL_W-1:0] trap_csr_stall   = front_four | b_mem_wb | b_wb;
  localparam logic [`CTRL_W-1:0] trap_csr_flush   = mid_three;

  // redirect squashes the two wrong-path slots
  localparam logic [`CTRL_W-1:0] jump_stall = b_if_id;
  localparam logic [`CTRL_W-1:0] jump_flush = b_if_id | b_id_ex;

  localparam logic [`CTRL_W-1:0] mul_div_stall  = b_pc | b_if_id | b_id_ex;
  localparam logic [`CTRL_W-1:0] mul_div_flush  = b_ex_mem;
  localparam logic [`CTRL_W-1:0] load_use_stall = b_pc | b_if_id;
  localparam logic [`CTRL_W-1:0] load_use_flush = b_id_ex;

  // everything but the writeback side cleared in reset
  localparam logic [`CTRL_W-1:0] reset_flush = front_four | b_mem_wb;

  always_comb begin
    if (rst) begin
      stall_o = '0;
      flush_o = reset_flush;
    end else if (ls_valid_i && !if_rdata_valid_i) begin
      stall_o = ram_mem_stall; // mem access starves fetch
      flush_o = ram_mem_flush;
    end else if (ram_stall_mem_i) begin
      stall_o = ram_mem_stall;
      flush_o = ram_mem_flush;
    end else if (ram_stall_if_i) begin
      stall_o = ram_if_stall;
      flush_o = ram_if_flush;
    end else if (trap_flush_i) begin
      stall_o = trap_flush_stall;
      flush_o = trap_flush_flush;
    end else if (trap_stall_i) begin
      stall_o = trap_csr_stall;
      flush_o = trap_csr_flush;
    end else if (jump_valid_i) begin
      stall_o = jump_stall;
      flush_o = jump_flush;
    end else if (mul_div_valid_i) begin
      stall_o = mul_div_stall;
      flush_o = mul_div_flush;
    end else if (load_use_valid_i) begin
      stall_o = load_use_stall;
      flush_o = load_use_flush;
    end else begin
      stall_o = '0; // free running
      flush_o = '0;
    end
  end

endmodule

/* design/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

  // r-type field split, other formats reuse the same bit positions
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_fields_t;

  // bit position of each register in the stall and flush vectors
  typedef enum logic [2:0] {
    PC     = 3'd0,
    IF_ID  = 3'd1,
    ID_EX  = 3'd2,
    EX_MEM = 3'd3,
    MEM_WB = 3'd4,
    WB     = 3'd5
  } stage_e;

endpackage

/* design/pipe_ctrl_defines.svh */
`ifndef PIPE_CTRL_DEFINES_SVH
`define PIPE_CTRL_DEFINES_SVH

// datapath widths
`define PC_W    32
`define INSTR_W 32

// one bit per register: pc, if/id, id/ex, ex/mem, mem/wb, writeback side
`define CTRL_W 6

// cycles a mul/div occupies execute
`define MUL_DIV_CYCLES 4

// rv32 major opcodes seen by the hazard logic
`define OP_LOAD  7'b0000011
`define OP_STORE 7'b0100011
`define OP_JAL   7'b1101111
`define OP_OP    7'b0110011 // funct7[0] set selects mul/div

`endif
